//--- logic/sample_conditioner_params.svh
// Width, depth, gain format and clamp window constants for the sample conditioner.
// Include this in every file that needs a sizing constant.
`ifndef SAMPLE_CONDITIONER_PARAMS_SVH
`define SAMPLE_CONDITIONER_PARAMS_SVH

// Signed input and output samples
`define SC_DATA_WIDTH 16
// Signed calibrated value before clamping
`define SC_WIDE_WIDTH 25
// Channel tag width, 8 channels
`define SC_CHANNEL_WIDTH 3
`define SC_USER_WIDTH 8
// Default FIFO depth in words
`define SC_FIFO_DEPTH 16
// Gains are unsigned Q8.8, so 256 is a gain of one
`define SC_GAIN_FRAC 8
// Clamp window applied by the range limiter
`define SC_LIMIT_MAX 30000
`define SC_LIMIT_MIN (-30000)

`endif

//--- logic/sample_conditioner_pkg.sv
// Shared sample, tag and calibration types for the sample conditioner.
// Refer to these by scoped name from the RTL and the testbench.
`include "sample_conditioner_params.svh"

package sample_conditioner_pkg;

    // Raw ADC sample as it enters and leaves the pipeline
    typedef logic signed [`SC_DATA_WIDTH-1:0] sample_t;

    // Calibrated value, wide enough for the worst case offset and gain
    typedef logic signed [`SC_WIDE_WIDTH-1:0] wide_t;

    // Channel tag carried on the dest field of the stream
    typedef logic [`SC_CHANNEL_WIDTH-1:0] channel_t;

    // Free user tag, passed through untouched
    typedef logic [`SC_USER_WIDTH-1:0] user_t;

    // Unsigned gain with SC_GAIN_FRAC fractional bits
    typedef logic [15:0] gain_t;

    // One calibration table entry, gain in the upper half
    typedef struct packed {
        gain_t   gain;
        sample_t offset;
    } cal_entry_t;

endpackage

//--- logic/sample_stream_if.sv
// Valid/ready sample stream carrying data, channel tag, user tag and packet end.
// WIDTH sizes the data field so the same bundle serves narrow and wide stages.
`timescale 1ns/1ps
`include "sample_conditioner_params.svh"

interface sample_stream_if #(
    parameter int WIDTH = `SC_DATA_WIDTH
);

    logic [WIDTH-1:0]                  data;
    sample_conditioner_pkg::channel_t dest;
    sample_conditioner_pkg::user_t    user;
    logic                              last;
    logic                              valid;
    logic                              ready;

    // A word moves on a rising edge where valid and ready are both high.
    // While stalled the producer holds valid and the whole payload steady
    modport source (
        output data,
        output dest,
        output user,
        output last,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  dest,
        input  user,
        input  last,
        input  valid,
        output ready
    );

endinterface

//--- logic/sample_fifo.sv
// Elastic circular-buffer FIFO at the head of the conditioning pipeline.
// Absorbs input bursts and presents the oldest word on its output stream.
`timescale 1ns/1ps
`include "sample_conditioner_params.svh"

module sample_fifo #(
    parameter int DEPTH = `SC_FIFO_DEPTH
) (
    input logic             clock,
    input logic             reset,
    sample_stream_if.sink   in,
    sample_stream_if.source out
);

    localparam int ADDR_WIDTH  = $clog2(DEPTH);
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);
    // Data, dest, user and last are kept side by side in one word
    localparam int ENTRY_WIDTH = `SC_DATA_WIDTH + `SC_CHANNEL_WIDTH + `SC_USER_WIDTH + 1;

    logic [ENTRY_WIDTH-1:0] storage [DEPTH];
    logic [ADDR_WIDTH-1:0]  write_ptr;
    logic [ADDR_WIDTH-1:0]  read_ptr;
    logic [COUNT_WIDTH-1:0] fill_count;
    logic                   push;
    logic                   pop;

    // Pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [ADDR_WIDTH-1:0] next_ptr(input logic [ADDR_WIDTH-1:0] ptr);
        if (ptr == ADDR_WIDTH'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Space is free unless every slot is taken
    assign in.ready  = (fill_count != COUNT_WIDTH'(DEPTH));
    assign out.valid = (fill_count != '0);

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    // Head word is read straight from storage so a new word can leave one edge after entry
    assign {out.last, out.user, out.dest, out.data} = storage[read_ptr];

    // Payload storage, written on every accepted word
    always_ff @(posedge clock) begin
        if (push) begin
            storage[write_ptr] <= {in.last, in.user, in.dest, in.data};
        end
    end

    // Pointer and fill tracking, both ends may move in the same cycle
    always_ff @(posedge clock) begin
        if (!reset) begin
            write_ptr  <= '0;
            read_ptr   <= '0;
            fill_count <= '0;
        end else begin
            if (push) begin
                write_ptr <= next_ptr(write_ptr);
            end
            if (pop) begin
                read_ptr <= next_ptr(read_ptr);
            end
            case ({push, pop})
                2'b10:   fill_count <= fill_count + 1'b1;
                2'b01:   fill_count <= fill_count - 1'b1;
                default: fill_count <= fill_count;
            endcase
        end
    end

    // The fill count tracks the pointer distance, so a full buffer has met pointers
    full_pointers_meet: assert property (
        @(posedge clock) disable iff (!reset)
        (fill_count == COUNT_WIDTH'(DEPTH)) |-> (write_ptr == read_ptr)
    );

    // A full FIFO refuses the word and the upstream must keep offering it unchanged
    input_held_when_full: assert property (
        @(posedge clock) disable iff (!reset)
        (in.valid && !in.ready) |=>
            (in.valid && $stable(in.data) && $stable(in.dest)
             && $stable(in.user) && $stable(in.last))
    );

    // A stalled head word stays put until the calibrator takes it
    head_stable_on_stall: assert property (
        @(posedge clock) disable iff (!reset)
        (out.valid && !out.ready) |=>
            (out.valid && $stable(out.data) && $stable(out.dest)
             && $stable(out.user) && $stable(out.last))
    );

endmodule

//--- logic/channel_calibrator.sv
// Per-channel offset and gain correction, one register stage deep.
// The table is written through strobe ports and indexed by each sample's dest tag.
`timescale 1ns/1ps
`include "sample_conditioner_params.svh"

module channel_calibrator (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              cal_write,
    input  sample_conditioner_pkg::channel_t cal_channel,
    input  sample_conditioner_pkg::gain_t    cal_gain,
    input  sample_conditioner_pkg::sample_t  cal_offset,
    sample_stream_if.sink                     in,
    sample_stream_if.source                   out
);

    localparam int CHANNELS   = 1 << `SC_CHANNEL_WIDTH;
    localparam int GAIN_WIDTH = $bits(sample_conditioner_pkg::gain_t);
    // One extra bit so the offset subtraction cannot wrap
    localparam int DIFF_WIDTH = `SC_DATA_WIDTH + 1;
    // Signed difference times zero-extended gain
    localparam int PROD_WIDTH = DIFF_WIDTH + GAIN_WIDTH + 1;

    sample_conditioner_pkg::cal_entry_t cal_table [CHANNELS];
    sample_conditioner_pkg::cal_entry_t entry;
    sample_conditioner_pkg::wide_t      scaled;
    logic signed [DIFF_WIDTH-1:0]       diff;
    logic signed [PROD_WIDTH-1:0]       product;
    logic                               accept;

    // Calibration table, identity on every channel out of reset.
    // A write lands on the edge so it applies to samples accepted afterwards
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < CHANNELS; i++) begin
                cal_table[i].gain   <= GAIN_WIDTH'(1 << `SC_GAIN_FRAC);
                cal_table[i].offset <= '0;
            end
        end else if (cal_write) begin
            cal_table[cal_channel].gain   <= cal_gain;
            cal_table[cal_channel].offset <= cal_offset;
        end
    end

    assign entry = cal_table[in.dest];

    // Sign-extend both operands before subtracting
    assign diff = $signed({in.data[`SC_DATA_WIDTH-1], in.data})
                - $signed({entry.offset[`SC_DATA_WIDTH-1], entry.offset});

    assign product = diff * $signed({1'b0, entry.gain});

    // Dropping the fraction bits of a two's complement value rounds toward minus infinity.
    // The top product bit is only a sign copy for any reachable input
    assign scaled = product[`SC_GAIN_FRAC +: `SC_WIDE_WIDTH];

    // Room exists when the register is empty or is being emptied this cycle
    assign in.ready = !out.valid || out.ready;
    assign accept   = in.valid && in.ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            out.valid <= 1'b0;
        end else if (accept) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    // Result register travels with its tags
    always_ff @(posedge clock) begin
        if (accept) begin
            out.data <= scaled;
            out.dest <= in.dest;
            out.user <= in.user;
            out.last <= in.last;
        end
    end

    // The limiter may stall, and the pending result must not change under it
    output_stable_on_stall: assert property (
        @(posedge clock) disable iff (!reset)
        (out.valid && !out.ready) |=>
            (out.valid && $stable(out.data) && $stable(out.dest)
             && $stable(out.user) && $stable(out.last))
    );

endmodule

//--- logic/range_limiter.sv
// Final clamp stage, one register deep, with the sink's own plain output ports.
// Saturates calibrated values to the output window and flags each clipped sample.
`timescale 1ns/1ps
`include "sample_conditioner_params.svh"

module range_limiter (
    input  logic                              clock,
    input  logic                              reset,
    sample_stream_if.sink                     in,
    output sample_conditioner_pkg::sample_t  out_data,
    output sample_conditioner_pkg::channel_t out_dest,
    output sample_conditioner_pkg::user_t    out_user,
    output logic                              out_last,
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic                              out_clipped
);

    sample_conditioner_pkg::wide_t   value;
    sample_conditioner_pkg::sample_t clamped;
    logic                            clip;
    logic                            accept;

    assign value = in.data;

    // Compare against the window in full width before narrowing
    always_comb begin
        if (value > `SC_LIMIT_MAX) begin
            clamped = `SC_DATA_WIDTH'(`SC_LIMIT_MAX);
            clip    = 1'b1;
        end else if (value < `SC_LIMIT_MIN) begin
            clamped = `SC_DATA_WIDTH'(`SC_LIMIT_MIN);
            clip    = 1'b1;
        end else begin
            clamped = value[`SC_DATA_WIDTH-1:0];
            clip    = 1'b0;
        end
    end

    // Same single-slot handshake as the calibrator
    assign in.ready = !out_valid || out_ready;
    assign accept   = in.valid && in.ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid   <= 1'b0;
            out_clipped <= 1'b0;
        end else if (accept) begin
            out_valid   <= 1'b1;
            out_clipped <= clip;
        end else if (out_ready) begin
            out_valid   <= 1'b0;
            out_clipped <= 1'b0;
        end
    end

    // Tags pass through unchanged next to the clamped value
    always_ff @(posedge clock) begin
        if (accept) begin
            out_data <= clamped;
            out_dest <= in.dest;
            out_user <= in.user;
            out_last <= in.last;
        end
    end

endmodule

//--- logic/sample_conditioner_top.sv
// Top level of the sample conditioner: FIFO, calibrator and limiter in a row.
// Streams and calibration writes are exposed as plain ports for the integrator.
`timescale 1ns/1ps
`include "sample_conditioner_params.svh"

module sample_conditioner_top (
    input  logic                              clock,
    input  logic                              reset,

    // Input sample stream
    input  sample_conditioner_pkg::sample_t  in_data,
    input  sample_conditioner_pkg::channel_t in_dest,
    input  sample_conditioner_pkg::user_t    in_user,
    input  logic                              in_last,
    input  logic                              in_valid,
    output logic                              in_ready,

    // Calibration table writes
    input  logic                              cal_write,
    input  sample_conditioner_pkg::channel_t cal_channel,
    input  sample_conditioner_pkg::gain_t    cal_gain,
    input  sample_conditioner_pkg::sample_t  cal_offset,

    // Conditioned output stream
    output sample_conditioner_pkg::sample_t  out_data,
    output sample_conditioner_pkg::channel_t out_dest,
    output sample_conditioner_pkg::user_t    out_user,
    output logic                              out_last,
    output logic                              out_valid,
    output logic                              out_clipped,
    input  logic                              out_ready
);

    // The FIFO's input port needs a bundle, so the plain inputs are gathered into one
    sample_stream_if #(.WIDTH(`SC_DATA_WIDTH)) in_stream ();
    sample_stream_if #(.WIDTH(`SC_DATA_WIDTH)) fifo_to_cal ();
    sample_stream_if #(.WIDTH(`SC_WIDE_WIDTH)) cal_to_lim ();

    assign in_stream.data  = in_data;
    assign in_stream.dest  = in_dest;
    assign in_stream.user  = in_user;
    assign in_stream.last  = in_last;
    assign in_stream.valid = in_valid;
    assign in_ready        = in_stream.ready;

    sample_fifo #(
        .DEPTH (`SC_FIFO_DEPTH)
    ) fifo_i (
        .clock (clock),
        .reset (reset),
        .in    (in_stream.sink),
        .out   (fifo_to_cal.source)
    );

    channel_calibrator calibrator_i (
        .clock       (clock),
        .reset       (reset),
        .cal_write   (cal_write),
        .cal_channel (cal_channel),
        .cal_gain    (cal_gain),
        .cal_offset  (cal_offset),
        .in          (fifo_to_cal.sink),
        .out         (cal_to_lim.source)
    );

    range_limiter limiter_i (
        .clock       (clock),
        .reset       (reset),
        .in          (cal_to_lim.sink),
        .out_data    (out_data),
        .out_dest    (out_dest),
        .out_user    (out_user),
        .out_last    (out_last),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_clipped (out_clipped)
    );

endmodule

//--- dv/tb_clock_gen.sv
// Free-running testbench clock and active-low power-on reset.
// Reset is released 1 ns after the last held rising edge.
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Held low for RESET_CYCLES rising edges so every register sees reset
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b1;
    end

endmodule

//--- dv/sample_conditioner_tb.sv
// Self-checking testbench for the sample conditioner pipeline.
// Drives random and directed streams, predicts every output and compares in order.
`timescale 1ns/1ps
`include "sample_conditioner_params.svh"

module sample_conditioner_tb;

    localparam int RESET_CYCLES  = 16;
    localparam int CHANNELS      = 1 << `SC_CHANNEL_WIDTH;
    localparam int BASIC_COUNT   = 60;
    localparam int MIXED_COUNT   = 80;
    localparam int EXTREME_COUNT = 16;
    localparam int STALL_COUNT   = 120;
    localparam int FULL_COUNT    = `SC_FIFO_DEPTH + 2;
    localparam int PLANNED       = BASIC_COUNT + MIXED_COUNT + EXTREME_COUNT
                                 + STALL_COUNT + FULL_COUNT;
    // Generous budget of 400 cycles per sample on top of the reset time
    localparam int WATCHDOG_CYCLES = PLANNED * 400 + RESET_CYCLES;

    // One predicted output beat
    typedef struct packed {
        sample_conditioner_pkg::sample_t  data;
        sample_conditioner_pkg::channel_t dest;
        sample_conditioner_pkg::user_t    user;
        logic                             last;
        logic                             clipped;
    } result_t;

    logic                             clock;
    logic                             reset;
    sample_conditioner_pkg::sample_t  in_data;
    sample_conditioner_pkg::channel_t in_dest;
    sample_conditioner_pkg::user_t    in_user;
    logic                             in_last;
    logic                             in_valid;
    logic                             in_ready;
    logic                             cal_write;
    sample_conditioner_pkg::channel_t cal_channel;
    sample_conditioner_pkg::gain_t    cal_gain;
    sample_conditioner_pkg::sample_t  cal_offset;
    sample_conditioner_pkg::sample_t  out_data;
    sample_conditioner_pkg::channel_t out_dest;
    sample_conditioner_pkg::user_t    out_user;
    logic                             out_last;
    logic                             out_valid;
    logic                             out_clipped;
    logic                             out_ready;

    // Testbench copy of the calibration table, updated with every write
    sample_conditioner_pkg::cal_entry_t cal_model [CHANNELS];
    result_t expected_q [$];
    int      value_errors;
    int      other_errors;
    int      accepted_count;
    int      received_count;
    logic    stim_done;

    tb_clock_gen #(
        .PERIOD       (10),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    sample_conditioner_top dut_i (
        .clock       (clock),
        .reset       (reset),
        .in_data     (in_data),
        .in_dest     (in_dest),
        .in_user     (in_user),
        .in_last     (in_last),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .cal_write   (cal_write),
        .cal_channel (cal_channel),
        .cal_gain    (cal_gain),
        .cal_offset  (cal_offset),
        .out_data    (out_data),
        .out_dest    (out_dest),
        .out_user    (out_user),
        .out_last    (out_last),
        .out_valid   (out_valid),
        .out_clipped (out_clipped),
        .out_ready   (out_ready)
    );

    // Offset, Q8.8 gain, floor shift and clamp, all done in 64-bit integers
    function automatic result_t expected_sample(
        input sample_conditioner_pkg::sample_t  data,
        input sample_conditioner_pkg::channel_t dest,
        input sample_conditioner_pkg::user_t    user,
        input logic                             last
    );
        result_t result;
        longint  diff;
        longint  scaled;
        diff   = longint'(data) - longint'($signed(cal_model[dest].offset));
        scaled = (diff * longint'(cal_model[dest].gain)) >>> `SC_GAIN_FRAC;
        result.clipped = 1'b1;
        if (scaled > `SC_LIMIT_MAX) begin
            scaled = `SC_LIMIT_MAX;
        end else if (scaled < `SC_LIMIT_MIN) begin
            scaled = `SC_LIMIT_MIN;
        end else begin
            result.clipped = 1'b0;
        end
        result.data = sample_conditioner_pkg::sample_t'(scaled);
        result.dest = dest;
        result.user = user;
        result.last = last;
        return result;
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic load_random();
        in_data = sample_conditioner_pkg::sample_t'($urandom);
        in_dest = sample_conditioner_pkg::channel_t'($urandom);
        in_user = sample_conditioner_pkg::user_t'($urandom);
        in_last = ($urandom % 8) == 0;
    endtask

    // Presents the current payload and returns once it has been taken
    task automatic offer();
        in_valid = 1'b1;
        @(negedge clock);
        while (!in_ready) @(negedge clock);
        expected_q.push_back(expected_sample(in_data, in_dest, in_user, in_last));
        accepted_count++;
        @(posedge clock);
        #1;
        in_valid = 1'b0;
    endtask

    // Waits until every predicted sample has left, out_ready must be high
    task automatic drain();
        while (expected_q.size() != 0) @(posedge clock);
        @(posedge clock);
        #1;
    endtask

    // Called only with an empty pipeline, so the model and the DUT change together
    task automatic write_cal(input int channel, input int gain, input int offset);
        cal_channel = sample_conditioner_pkg::channel_t'(channel);
        cal_gain    = sample_conditioner_pkg::gain_t'(gain);
        cal_offset  = sample_conditioner_pkg::sample_t'(offset);
        cal_write   = 1'b1;
        @(posedge clock);
        #1;
        cal_write = 1'b0;
        cal_model[channel].gain   = sample_conditioner_pkg::gain_t'(gain);
        cal_model[channel].offset = sample_conditioner_pkg::sample_t'(offset);
    endtask

    // Out_ready held low, so FIFO plus the two stage registers fill up
    task automatic fill_under_backpressure();
        int   taken;
        logic took;
        taken     = 0;
        out_ready = 1'b0;
        load_random();
        in_valid = 1'b1;
        for (int i = 0; i < FULL_COUNT + 8; i++) begin
            @(negedge clock);
            took = in_ready;
            if (took) begin
                expected_q.push_back(expected_sample(in_data, in_dest, in_user, in_last));
                accepted_count++;
                taken++;
            end
            @(posedge clock);
            #1;
            if (took) begin
                load_random();
            end
        end
        if (taken != FULL_COUNT) begin
            $display("FAIL %0t: accepted %0d samples under stall, expected %0d",
                     $time, taken, FULL_COUNT);
            value_errors++;
        end
        if (in_ready !== 1'b0) begin
            $display("FAIL %0t: in_ready high with a full pipeline", $time);
            value_errors++;
        end
        out_ready = 1'b1;
        // The refused sample stays offered and enters once the output moves again
        offer();
        drain();
    endtask

    // Compare at the falling edge, where the coming transfer is already decided
    always @(negedge clock) begin
        result_t predicted;
        if (reset && out_valid === 1'b1 && out_ready === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("An output sample appeared at %0t with nothing outstanding", $time);
                other_errors++;
            end else begin
                predicted = expected_q.pop_front();
                received_count++;
                if (out_data !== predicted.data) begin
                    $display("FAIL %0t: data expected %0d got %0d", $time,
                             $signed(predicted.data), $signed(out_data));
                    value_errors++;
                end
                if (out_dest !== predicted.dest) begin
                    $display("FAIL %0t: dest expected %0d got %0d", $time,
                             predicted.dest, out_dest);
                    value_errors++;
                end
                if (out_user !== predicted.user) begin
                    $display("FAIL %0t: user expected %0h got %0h", $time,
                             predicted.user, out_user);
                    value_errors++;
                end
                if (out_last !== predicted.last) begin
                    $display("FAIL %0t: last expected %0b got %0b", $time,
                             predicted.last, out_last);
                    value_errors++;
                end
                if (out_clipped !== predicted.clipped) begin
                    $display("FAIL %0t: clipped expected %0b got %0b", $time,
                             predicted.clipped, out_clipped);
                    value_errors++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the pipeline stopped moving",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(59));
        in_data        = '0;
        in_dest        = '0;
        in_user        = '0;
        in_last        = 1'b0;
        in_valid       = 1'b0;
        cal_write      = 1'b0;
        cal_channel    = '0;
        cal_gain       = '0;
        cal_offset     = '0;
        out_ready      = 1'b1;
        stim_done      = 1'b0;
        value_errors   = 0;
        other_errors   = 0;
        accepted_count = 0;
        received_count = 0;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            cal_model[ch].gain   = sample_conditioner_pkg::gain_t'(1 << `SC_GAIN_FRAC);
            cal_model[ch].offset = '0;
        end

        wait (reset === 1'b1);
        @(posedge clock);
        #1;
        if (out_valid !== 1'b0 || out_clipped !== 1'b0 || in_ready !== 1'b1) begin
            $display("FAIL %0t: wrong state after reset valid=%b clipped=%b ready=%b",
                     $time, out_valid, out_clipped, in_ready);
            value_errors++;
        end

        // Identity table, so samples pass unchanged apart from the clamp
        repeat (BASIC_COUNT) begin
            load_random();
            offer();
        end
        drain();

        // Distinct gain and offset on every channel, then mixed traffic
        for (int ch = 0; ch < CHANNELS; ch++) begin
            write_cal(ch, 192 + ch * 29, ch * 150 - 500);
        end
        repeat (MIXED_COUNT) begin
            load_random();
            offer();
        end
        drain();

        // Extreme gains and offsets drive both limits and some in-range results
        write_cal(0, 16'hffff, 0);
        write_cal(1, 512, 1000);
        write_cal(2, 256, -32768);
        write_cal(3, 40000, 32767);
        for (int ch = 0; ch < 4; ch++) begin
            for (int k = 0; k < 4; k++) begin
                in_data = (k == 0) ? 16'sd32767 : (k == 1) ? -16'sd32768
                        : (k == 2) ? 16'sd64 : -16'sd64;
                in_dest = sample_conditioner_pkg::channel_t'(ch);
                in_user = sample_conditioner_pkg::user_t'(ch * 4 + k);
                in_last = (k == 3);
                offer();
            end
        end
        drain();

        // Random input gaps against a randomly stalling consumer
        fork
            begin
                repeat (STALL_COUNT) begin
                    load_random();
                    offer();
                    idle($urandom % 3);
                end
                stim_done = 1'b1;
            end
            begin
                while (!stim_done) begin
                    @(posedge clock);
                    #1;
                    out_ready = ($urandom % 3) != 0;
                end
            end
        join
        out_ready = 1'b1;
        drain();

        fill_under_backpressure();

        if (expected_q.size() != 0 || accepted_count != received_count) begin
            $display("Samples went missing, %0d accepted but %0d received",
                     accepted_count, received_count);
            other_errors++;
        end
        $display("Summary: %0d accepted, %0d received, %0d value errors, %0d other errors",
                 accepted_count, received_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+logic
logic/sample_conditioner_pkg.sv
logic/sample_stream_if.sv
logic/sample_fifo.sv
logic/channel_calibrator.sv
logic/range_limiter.sv
logic/sample_conditioner_top.sv
dv/tb_clock_gen.sv
dv/sample_conditioner_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the sample conditioner testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module sample_conditioner_tb -Mdir obj_dir \
    > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vsample_conditioner_tb > sim.log 2>&1
cat sim.log

grep -q "Test completed successfully" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
